//--- hw/host_if_consts.svh
// --------------------
// Host interface constants
// Widths, sizes, read latency and character codes
// --------------------

`ifndef HOST_IF_CONSTS_SVH
`define HOST_IF_CONSTS_SVH

// Internal bus
`define HOST_ADDR_W         16
`define HOST_DATA_W         8

// Line and reply capacity in bytes
`define HOST_LINE_BYTES     16
`define HOST_RESP_BYTES     6

// Cycles of read enable before the read byte is valid
`define HOST_RD_LATENCY     4

// Control register written by stop and start
`define HOST_CTRL_ADDR      16'h0000

`define HOST_CHAR_LF        8'h0A

`endif

//--- hw/host_if_pkg.sv
// --------------------
// Host interface types
// --------------------

`default_nettype none

`include "host_if_consts.svh"

package host_if_pkg;

    // One character or one bus data byte
    typedef logic [`HOST_DATA_W-1:0] byte_t;

    typedef logic [`HOST_ADDR_W-1:0] addr_t;

    // Received line, first character in the lowest byte
    typedef logic [`HOST_LINE_BYTES*`HOST_DATA_W-1:0] line_t;

    // Reply message, byte 0 goes out first, a zero byte ends it
    typedef logic [`HOST_RESP_BYTES*`HOST_DATA_W-1:0] resp_msg_t;

    // Decoded command
    typedef enum logic [2:0] {
        CMD_WRITE,
        CMD_READ,
        CMD_STOP,
        CMD_START,
        CMD_BAD
    } cmd_kind_e;

endpackage

`default_nettype wire

//--- hw/host_cmd_decode.sv
// --------------------
// Host command decoder
// Parses a received text line into a command, address and data
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "host_if_consts.svh"

module host_cmd_decode
    import host_if_pkg::*;
(
    input  wire         CLK,
    input  wire         RST_N,
    input  wire         line_valid,
    input  wire  line_t line_data,
    output logic        cmd_valid,
    output cmd_kind_e   cmd_kind,
    output addr_t       cmd_addr,
    output byte_t       cmd_data
);

    logic                       lv_q;
    logic                       rise_q;
    byte_t                      ch [`HOST_LINE_BYTES];
    logic [3*`HOST_DATA_W-1:0]  kw3;
    logic [4*`HOST_DATA_W-1:0]  kw4;
    logic [5*`HOST_DATA_W-1:0]  kw5;
    logic [4:0]                 addr_dig [4];
    logic [4:0]                 data_dig [2];
    logic                       addr_ok;
    logic                       data_ok;
    addr_t                      addr_val;
    byte_t                      data_val;
    cmd_kind_e                  kind;

    // Returns {ok, nibble} for one ASCII hex digit
    function automatic logic [4:0] hex_digit(input byte_t c);
        logic [4:0] r;
        if ((c >= "0") && (c <= "9")) begin
            r = {1'b1, c[3:0]};
        end else if (((c >= "a") && (c <= "f")) || ((c >= "A") && (c <= "F"))) begin
            // Low nibble of a..f and A..F is 1..6
            r = {1'b1, c[3:0] + 4'd9};
        end else begin
            r = 5'b0;
        end
        return r;
    endfunction

    always_comb begin
        for (int i = 0; i < `HOST_LINE_BYTES; i++) begin
            ch[i] = line_data[i*`HOST_DATA_W +: `HOST_DATA_W];
        end
    end

    // Keyword bytes, first character in the top byte
    assign kw3 = {ch[0], ch[1], ch[2]};
    assign kw4 = {kw3, ch[3]};
    assign kw5 = {kw4, ch[4]};

    // --------------------
    // Hex fields
    // --------------------
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            addr_dig[i] = hex_digit(ch[3+i]);
        end
        for (int i = 0; i < 2; i++) begin
            data_dig[i] = hex_digit(ch[8+i]);
        end
    end

    assign addr_ok  = addr_dig[0][4] & addr_dig[1][4] & addr_dig[2][4] & addr_dig[3][4];
    assign data_ok  = data_dig[0][4] & data_dig[1][4];
    assign addr_val = {addr_dig[0][3:0], addr_dig[1][3:0], addr_dig[2][3:0], addr_dig[3][3:0]};
    assign data_val = {data_dig[0][3:0], data_dig[1][3:0]};

    // --------------------
    // Command kind
    // --------------------
    always_comb begin
        if ((kw4 == "stop") || (kw4 == "STOP")) begin
            kind = CMD_STOP;
        end else if ((kw5 == "start") || (kw5 == "START")) begin
            kind = CMD_START;
        end else if (((kw3 == "rd ") || (kw3 == "RD ")) &&
                     (ch[7] == `HOST_CHAR_LF) && addr_ok) begin
            kind = CMD_READ;
        end else if (((kw3 == "wr ") || (kw3 == "WR ")) && (ch[7] == " ") &&
                     (ch[10] == `HOST_CHAR_LF) && addr_ok && data_ok) begin
            kind = CMD_WRITE;
        end else begin
            kind = CMD_BAD;
        end
    end

    // Edge detect, then one more stage for the registered result
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            lv_q      <= 1'b0;
            rise_q    <= 1'b0;
            cmd_valid <= 1'b0;
        end else begin
            lv_q      <= line_valid;
            rise_q    <= line_valid & ~lv_q;
            cmd_valid <= rise_q;
        end
    end

    always_ff @(posedge CLK) begin
        if (rise_q) begin
            cmd_kind <= kind;
            cmd_addr <= addr_val;
            cmd_data <= data_val;
        end
    end

endmodule

`default_nettype wire

//--- hw/host_bus_access.sv
// --------------------
// Host bus sequencer
// Runs the bus access of a command and builds the reply
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "host_if_consts.svh"

module host_bus_access
    import host_if_pkg::*;
(
    input  wire             CLK,
    input  wire             RST_N,
    input  wire             cmd_valid,
    input  wire  cmd_kind_e cmd_kind,
    input  wire  addr_t     cmd_addr,
    input  wire  byte_t     cmd_data,
    output addr_t           bus_addr,
    output logic            bus_we,
    output logic            bus_re,
    output byte_t           bus_wdata,
    input  wire  byte_t     bus_rdata,
    output logic            msg_load,
    output resp_msg_t       msg,
    input  wire             msg_done
);

    localparam int CNT_W = $clog2(`HOST_RD_LATENCY + 1);

    // Replies with the first character in the lowest byte
    localparam resp_msg_t MSG_OK   = {8'h00, 8'h00, 8'h00, `HOST_CHAR_LF, "K", "O"};
    localparam resp_msg_t MSG_NG   = {8'h00, 8'h00, 8'h00, `HOST_CHAR_LF, "G", "N"};
    localparam resp_msg_t MSG_NONE = '0;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ_WAIT,
        ST_LOAD,
        ST_WAIT_DONE
    } state_e;

    state_e             state;
    logic [CNT_W-1:0]   lat_cnt;
    logic               rd_last;
    resp_msg_t          rd_msg;

    // Upper-case ASCII hex character
    function automatic byte_t hex_char(input logic [3:0] n);
        byte_t c;
        if (n < 4'd10) begin
            c = {4'h3, n};
        end else begin
            c = 8'h37 + {4'h0, n};
        end
        return c;
    endfunction

    assign rd_last = (state == ST_READ_WAIT) && (lat_cnt == '0);
    assign rd_msg  = {`HOST_CHAR_LF, hex_char(bus_rdata[3:0]), hex_char(bus_rdata[7:4]),
                      `HOST_CHAR_LF, "K", "O"};

    // Strobes decoded from the state
    assign bus_we   = (state == ST_WRITE);
    assign bus_re   = (state == ST_READ_WAIT);
    assign msg_load = (state == ST_LOAD);

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state   <= ST_IDLE;
            lat_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_valid) begin
                        case (cmd_kind)
                            CMD_READ: begin
                                state   <= ST_READ_WAIT;
                                lat_cnt <= CNT_W'(`HOST_RD_LATENCY - 1);
                            end
                            CMD_BAD: begin
                                state <= ST_LOAD;
                            end
                            default: begin
                                state <= ST_WRITE;
                            end
                        endcase
                    end
                end
                ST_WRITE: begin
                    state <= ST_LOAD;
                end
                ST_READ_WAIT: begin
                    if (lat_cnt == '0) begin
                        state <= ST_LOAD;
                    end else begin
                        lat_cnt <= lat_cnt - 1'b1;
                    end
                end
                ST_LOAD: begin
                    state <= ST_WAIT_DONE;
                end
                ST_WAIT_DONE: begin
                    if (msg_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // --------------------
    // Address, data and reply
    // --------------------
    always_ff @(posedge CLK) begin
        if ((state == ST_IDLE) && cmd_valid) begin
            case (cmd_kind)
                CMD_WRITE: begin
                    bus_addr  <= cmd_addr;
                    bus_wdata <= cmd_data;
                    msg       <= MSG_OK;
                end
                CMD_READ: begin
                    bus_addr <= cmd_addr;
                end
                CMD_STOP: begin
                    bus_addr  <= `HOST_CTRL_ADDR;
                    bus_wdata <= 8'h01;
                    msg       <= MSG_OK;
                end
                CMD_START: begin
                    bus_addr  <= `HOST_CTRL_ADDR;
                    bus_wdata <= 8'h00;
                    msg       <= MSG_NONE;
                end
                default: begin
                    msg <= MSG_NG;
                end
            endcase
        end else if (rd_last) begin
            // Read byte taken on the last enable cycle
            msg <= rd_msg;
        end
    end

endmodule

`default_nettype wire

//--- hw/host_resp_buffer.sv
// --------------------
// Reply byte holder
// Releases the reply one byte at a time and flags its end
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "host_if_consts.svh"

module host_resp_buffer
    import host_if_pkg::*;
(
    input  wire             CLK,
    input  wire             RST_N,
    input  wire             msg_load,
    input  wire  resp_msg_t msg,
    input  wire             byte_taken,
    output logic            byte_valid,
    output byte_t           byte_data,
    output logic            msg_done
);

    resp_msg_t  msg_q;
    logic       pending;

    // Head byte goes out next
    assign byte_data  = msg_q[`HOST_DATA_W-1:0];
    assign byte_valid = (byte_data != '0);

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            msg_q    <= '0;
            pending  <= 1'b0;
            msg_done <= 1'b0;
        end else begin
            msg_done <= 1'b0;
            if (msg_load) begin
                msg_q   <= msg;
                pending <= 1'b1;
            end else begin
                // Zeros fill in from the top
                if (byte_taken) begin
                    msg_q <= msg_q >> `HOST_DATA_W;
                end
                // Loaded message fully handed over
                if (pending && !byte_valid) begin
                    msg_done <= 1'b1;
                    pending  <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/host_uart_sender.sv
// --------------------
// UART byte sender
// Hands reply bytes to the UART paced by its busy level
// --------------------

`timescale 1ns/1ps
`default_nettype none

module host_uart_sender
    import host_if_pkg::*;
(
    input  wire         CLK,
    input  wire         RST_N,
    input  wire         byte_valid,
    input  wire  byte_t byte_data,
    output logic        byte_taken,
    input  wire         tx_busy,
    output logic        tx_de,
    output byte_t       tx_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_BUSY,
        ST_WAIT_READY
    } state_e;

    state_e state;
    logic   take;

    assign take = (state == ST_IDLE) && byte_valid;

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state      <= ST_IDLE;
            tx_de      <= 1'b0;
            byte_taken <= 1'b0;
        end else begin
            byte_taken <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (byte_valid) begin
                        tx_de      <= 1'b1;
                        byte_taken <= 1'b1;
                        state      <= ST_WAIT_BUSY;
                    end
                end
                // Hold the byte until the UART accepts it
                ST_WAIT_BUSY: begin
                    if (tx_busy) begin
                        tx_de <= 1'b0;
                        state <= ST_WAIT_READY;
                    end
                end
                ST_WAIT_READY: begin
                    if (!tx_busy) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    tx_de <= 1'b0;
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (take) begin
            tx_data <= byte_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/host_if_top.sv
// --------------------
// Host command interface top
// --------------------

`timescale 1ns/1ps
`default_nettype none

module host_if_top
    import host_if_pkg::*;
(
    input  wire         CLK,
    input  wire         RST_N,
    // Receive buffer
    input  wire         line_valid,
    input  wire  line_t line_data,
    output logic        line_clr,
    // Internal bus
    output addr_t       bus_addr,
    output logic        bus_we,
    output logic        bus_re,
    output byte_t       bus_wdata,
    input  wire  byte_t bus_rdata,
    // UART transmitter
    input  wire         tx_busy,
    output logic        tx_de,
    output byte_t       tx_data
);

    logic       cmd_valid;
    cmd_kind_e  cmd_kind;
    addr_t      cmd_addr;
    byte_t      cmd_data;
    logic       msg_load;
    resp_msg_t  msg;
    logic       byte_valid;
    byte_t      byte_data;
    logic       byte_taken;

    host_cmd_decode u_host_cmd_decode (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .line_valid (line_valid),
        .line_data  (line_data),
        .cmd_valid  (cmd_valid),
        .cmd_kind   (cmd_kind),
        .cmd_addr   (cmd_addr),
        .cmd_data   (cmd_data)
    );

    host_bus_access u_host_bus_access (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .cmd_valid  (cmd_valid),
        .cmd_kind   (cmd_kind),
        .cmd_addr   (cmd_addr),
        .cmd_data   (cmd_data),
        .bus_addr   (bus_addr),
        .bus_we     (bus_we),
        .bus_re     (bus_re),
        .bus_wdata  (bus_wdata),
        .bus_rdata  (bus_rdata),
        .msg_load   (msg_load),
        .msg        (msg),
        .msg_done   (line_clr)
    );

    // End of reply also clears the receive buffer
    host_resp_buffer u_host_resp_buffer (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .msg_load   (msg_load),
        .msg        (msg),
        .byte_taken (byte_taken),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .msg_done   (line_clr)
    );

    host_uart_sender u_host_uart_sender (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .byte_taken (byte_taken),
        .tx_busy    (tx_busy),
        .tx_de      (tx_de),
        .tx_data    (tx_data)
    );

endmodule

`default_nettype wire

//--- testbench/tb_host_if.sv
// --------------------
// Host interface testbench
// Random commands against bus, UART and reply models
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "host_if_consts.svh"

module tb_host_if
    import host_if_pkg::*;
();

    // Expected command kinds
    localparam int K_WR    = 0;
    localparam int K_RD    = 1;
    localparam int K_STOP  = 2;
    localparam int K_START = 3;
    localparam int K_BAD   = 4;

    localparam int TIMEOUT = 2000;
    localparam int PAIRS   = 40;

    logic   CLK;
    logic   RST_N;
    logic   line_valid;
    line_t  line_data;
    logic   line_clr;
    addr_t  bus_addr;
    logic   bus_we;
    logic   bus_re;
    byte_t  bus_wdata;
    byte_t  bus_rdata = '0;
    logic   tx_busy = 1'b0;
    logic   tx_de;
    byte_t  tx_data;

    integer seed;
    int     errors;
    int     checks;
    int     lines_sent;
    bit     timed_out;

    byte_t  mem [0:65535];
    byte_t  ref_mem [0:65535];
    byte_t  txt [0:`HOST_LINE_BYTES-1];
    byte_t  exp_q [$];
    byte_t  tx_q [$];
    int     re_runs [$];

    // Observed bus activity of the current line
    int     we_cnt;
    addr_t  we_addr;
    byte_t  we_data;
    int     re_len;
    addr_t  re_addr;
    bit     re_moved;
    int     clr_cnt;
    int     u_state;
    int     u_cnt;

    host_if_top u_host_if_top (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .line_valid (line_valid),
        .line_data  (line_data),
        .line_clr   (line_clr),
        .bus_addr   (bus_addr),
        .bus_we     (bus_we),
        .bus_re     (bus_re),
        .bus_wdata  (bus_wdata),
        .bus_rdata  (bus_rdata),
        .tx_busy    (tx_busy),
        .tx_de      (tx_de),
        .tx_data    (tx_data)
    );

    initial begin
        CLK = 1'b0;
    end

    always #10 CLK = ~CLK;

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $unsigned($random(seed)) % (hi - lo + 1);
        return lo + r;
    endfunction

    function automatic byte_t fill_pattern(input addr_t a);
        return a[15:8] ^ {a[4:0], a[7:5]} ^ 8'h3C;
    endfunction

    function automatic byte_t hex_ascii(input logic [3:0] n, input bit upper);
        byte_t c;
        if (n < 4'd10) begin
            c = "0" + {4'h0, n};
        end else if (upper) begin
            c = "A" + {4'h0, n - 4'd10};
        end else begin
            c = "a" + {4'h0, n - 4'd10};
        end
        return c;
    endfunction

    task automatic check_val(input string name, input int exp_v, input int got_v);
        checks++;
        if (exp_v != got_v) begin
            errors++;
            $display("[FAIL] t=%0t %s exp=%0h got=%0h", $time, name, exp_v, got_v);
        end
    endtask

    // --------------------
    // Bus memory and UART models
    // --------------------
    always @(posedge CLK) begin
        if (bus_we) begin
            mem[bus_addr] <= bus_wdata;
        end
        if (bus_re) begin
            bus_rdata <= mem[bus_addr];
        end
    end

    // Busy rises 1..3 cycles after tx_de and holds 1..8 cycles
    always @(posedge CLK) begin
        if (!RST_N) begin
            u_state = 0;
            tx_busy <= 1'b0;
        end else begin
            case (u_state)
                0: begin
                    if (tx_de) begin
                        tx_q.push_back(tx_data);
                        u_cnt   = rand_range(0, 2);
                        u_state = 1;
                    end
                end
                1: begin
                    if (u_cnt == 0) begin
                        tx_busy <= 1'b1;
                        u_cnt   = rand_range(1, 8);
                        u_state = 2;
                    end else begin
                        u_cnt--;
                    end
                end
                default: begin
                    if (u_cnt == 1) begin
                        tx_busy <= 1'b0;
                        u_state = 0;
                    end else begin
                        u_cnt--;
                    end
                end
            endcase
        end
    end

    // Bus and line_clr monitor
    always @(posedge CLK) begin
        if (RST_N) begin
            if (bus_we) begin
                we_cnt++;
                we_addr = bus_addr;
                we_data = bus_wdata;
            end
            if (bus_re) begin
                if (re_len == 0) begin
                    re_addr = bus_addr;
                end else if (bus_addr != re_addr) begin
                    re_moved = 1'b1;
                end
                re_len++;
            end else if (re_len != 0) begin
                re_runs.push_back(re_len);
                re_len = 0;
            end
            if (line_clr) begin
                clr_cnt++;
            end
        end
    end

    // --------------------
    // Line building
    // --------------------
    task automatic clear_text();
        for (int i = 0; i < `HOST_LINE_BYTES; i++) begin
            txt[i] = 8'h00;
        end
    endtask

    task automatic put_text(input int pos, input string s);
        for (int i = 0; i < s.len(); i++) begin
            txt[pos+i] = s[i];
        end
    endtask

    task automatic put_hex(input int pos, input addr_t a, input bit up);
        for (int i = 0; i < 4; i++) begin
            txt[pos+i] = hex_ascii(a[15-4*i -: 4], up);
        end
    endtask

    function automatic line_t pack_line();
        line_t l;
        for (int i = 0; i < `HOST_LINE_BYTES; i++) begin
            l[i*`HOST_DATA_W +: `HOST_DATA_W] = txt[i];
        end
        return l;
    endfunction

    task automatic build_write(input addr_t a, input byte_t d, input bit up_kw, input bit up_hex);
        string kw;
        kw = "wr ";
        if (up_kw) begin
            kw = kw.toupper();
        end
        clear_text();
        put_text(0, kw);
        put_hex(3, a, up_hex);
        txt[7]  = " ";
        txt[8]  = hex_ascii(d[7:4], up_hex);
        txt[9]  = hex_ascii(d[3:0], up_hex);
        txt[10] = `HOST_CHAR_LF;
    endtask

    task automatic build_read(input addr_t a, input bit up_kw, input bit up_hex);
        string kw;
        kw = "rd ";
        if (up_kw) begin
            kw = kw.toupper();
        end
        clear_text();
        put_text(0, kw);
        put_hex(3, a, up_hex);
        txt[7] = `HOST_CHAR_LF;
    endtask

    // --------------------
    // Reference model, line driver and checker
    // --------------------
    task automatic run_line(input int kind, input addr_t addr, input byte_t data);
        int     exp_we;
        int     exp_re;
        addr_t  exp_addr;
        byte_t  exp_wdata;
        byte_t  rd;
        int     n;
        bit     seen;
        if (timed_out) begin
            return;
        end
        exp_q.delete();
        tx_q.delete();
        re_runs.delete();
        we_cnt    = 0;
        re_moved  = 1'b0;
        clr_cnt   = 0;
        exp_we    = 0;
        exp_re    = 0;
        exp_addr  = `HOST_CTRL_ADDR;
        exp_wdata = 8'h00;
        case (kind)
            K_WR: begin
                exp_we    = 1;
                exp_addr  = addr;
                exp_wdata = data;
            end
            K_RD: begin
                exp_re   = 1;
                exp_addr = addr;
            end
            K_STOP: begin
                exp_we    = 1;
                exp_wdata = 8'h01;
            end
            K_START: begin
                exp_we = 1;
            end
            default: begin
            end
        endcase
        if (exp_we == 1) begin
            ref_mem[exp_addr] = exp_wdata;
        end
        if (kind == K_BAD) begin
            exp_q.push_back("N");
            exp_q.push_back("G");
            exp_q.push_back(`HOST_CHAR_LF);
        end else if (kind != K_START) begin
            exp_q.push_back("O");
            exp_q.push_back("K");
            exp_q.push_back(`HOST_CHAR_LF);
        end
        if (kind == K_RD) begin
            rd = ref_mem[addr];
            exp_q.push_back(hex_ascii(rd[7:4], 1'b1));
            exp_q.push_back(hex_ascii(rd[3:0], 1'b1));
            exp_q.push_back(`HOST_CHAR_LF);
        end

        @(posedge CLK);
        line_data  <= pack_line();
        line_valid <= 1'b1;
        lines_sent++;
        n    = 0;
        seen = 1'b0;
        while (!seen && (n < TIMEOUT)) begin
            @(posedge CLK);
            if (line_clr) begin
                seen = 1'b1;
            end
            n++;
        end
        line_valid <= 1'b0;
        if (!seen) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: no line_clr within %0d cycles for line %0d", TIMEOUT, lines_sent);
            return;
        end
        // Let any stray strobe show up before checking
        repeat (4) @(posedge CLK);
        @(negedge CLK);

        check_val("bus_we count", exp_we, we_cnt);
        if (exp_we == 1) begin
            check_val("bus_addr", exp_addr, we_addr);
            check_val("bus_wdata", exp_wdata, we_data);
        end
        check_val("bus_re count", exp_re, re_runs.size());
        foreach (re_runs[i]) begin
            check_val("bus_re length", `HOST_RD_LATENCY, re_runs[i]);
        end
        if (exp_re == 1 && re_runs.size() == 1) begin
            check_val("bus_addr", exp_addr, re_addr);
        end
        if (re_moved) begin
            errors++;
            $display("bus_addr changed while bus_re was high, line %0d", lines_sent);
        end
        check_val("line_clr count", 1, clr_cnt);
        check_val("tx byte count", exp_q.size(), tx_q.size());
        for (int i = 0; (i < exp_q.size()) && (i < tx_q.size()); i++) begin
            check_val("tx_data", exp_q[i], tx_q[i]);
        end
    endtask

    task automatic run_text(input string s, input int kind, input addr_t addr, input byte_t data);
        clear_text();
        put_text(0, s);
        run_line(kind, addr, data);
    endtask

    initial begin
        addr_t a;
        byte_t d;
        seed       = 32'h18c7f640;
        errors     = 0;
        checks     = 0;
        lines_sent = 0;
        timed_out  = 1'b0;
        re_len     = 0;
        RST_N      = 1'b0;
        line_valid = 1'b0;
        line_data  = '0;
        for (int i = 0; i < 65536; i++) begin
            mem[i]     = fill_pattern(addr_t'(i));
            ref_mem[i] = fill_pattern(addr_t'(i));
        end
        repeat (8) @(posedge CLK);
        RST_N <= 1'b1;
        repeat (2) @(posedge CLK);
        @(negedge CLK);

        // Both keyword cases, hex digits a-f and A-F
        run_text("wr abcd ef\n", K_WR, 16'hABCD, 8'hEF);
        run_text("RD ABCD\n", K_RD, 16'hABCD, 8'h00);
        run_text("WR ABCD 5a\n", K_WR, 16'hABCD, 8'h5A);
        run_text("rd aBcD\n", K_RD, 16'hABCD, 8'h00);

        // Control register
        run_text("stop\n", K_STOP, 16'h0000, 8'h00);
        run_text("rd 0000\n", K_RD, 16'h0000, 8'h00);
        run_text("START\n", K_START, 16'h0000, 8'h00);
        run_text("RD 0000\n", K_RD, 16'h0000, 8'h00);
        run_text("STOP now\n", K_STOP, 16'h0000, 8'h00);
        run_text("start 1\n", K_START, 16'h0000, 8'h00);

        // Malformed lines
        run_text("xx 1234\n", K_BAD, 16'h0000, 8'h00);
        run_text("wr 1234-56\n", K_BAD, 16'h0000, 8'h00);
        run_text("rd 1234 5", K_BAD, 16'h0000, 8'h00);
        run_text("wr 0010 11", K_BAD, 16'h0000, 8'h00);
        run_text("rd 12g4\n", K_BAD, 16'h0000, 8'h00);
        run_text("wr 00a1 5z\n", K_BAD, 16'h0000, 8'h00);
        run_text("Wr 0010 11\n", K_BAD, 16'h0000, 8'h00);
        run_text("sTop\n", K_BAD, 16'h0000, 8'h00);

        // Random write and read back, plus reads of untouched locations
        for (int k = 0; k < PAIRS; k++) begin
            a = addr_t'(rand_range(0, 65535));
            d = byte_t'(rand_range(0, 255));
            build_write(a, d, rand_range(0, 1) == 1, rand_range(0, 1) == 1);
            run_line(K_WR, a, d);
            build_read(a, rand_range(0, 1) == 1, rand_range(0, 1) == 1);
            run_line(K_RD, a, 8'h00);
            if ((k % 4) == 3) begin
                a = addr_t'(rand_range(0, 65535));
                build_read(a, rand_range(0, 1) == 1, rand_range(0, 1) == 1);
                run_line(K_RD, a, 8'h00);
            end
        end

        $display("Lines: %0d, checks: %0d, errors: %0d", lines_sent, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- host_if_top.f
+incdir+hw
hw/host_if_pkg.sv
hw/host_cmd_decode.sv
hw/host_bus_access.sv
hw/host_resp_buffer.sv
hw/host_uart_sender.sv
hw/host_if_top.sv
testbench/tb_host_if.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the host interface testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --top-module tb_host_if -f host_if_top.f \
    --Mdir "$BUILD_DIR" -o sim_tb_host_if
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb_host_if" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    exit 1
fi
exit 0
